/* include/dsp_settings.svh */
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// Lanes per input vector
`define LANES 8

// Signed ADC code
`define CODE_W 8

// Feed-forward equalizer
`define FFE_TAPS 3
`define FFE_COEF_W 8
`define FFE_SHIFT_W 4

// Equalized estimate and slicer threshold
`define EST_W 10

// Channel estimate for rebuilding the expected code
`define CHAN_TAPS 3
`define CHAN_COEF_W 8
`define CHAN_SHIFT_W 3

// Residual error after saturation
`define ERR_W 10

`endif

/* logic/dsp_pkg.sv */
`include "dsp_settings.svh"
`default_nettype none

package dsp_pkg;

    // Scalar element types, all signed
    typedef logic signed [`CODE_W-1:0] code_t;
    typedef logic signed [`FFE_COEF_W-1:0] ffe_coef_t;
    typedef logic signed [`EST_W-1:0] est_t;
    typedef logic signed [`CHAN_COEF_W-1:0] chan_coef_t;
    typedef logic signed [`ERR_W-1:0] err_t;

    // One cycle of ADC input, lane 0 is the earliest symbol
    typedef code_t [`LANES-1:0] code_vec_t;

    // Codes seen by one lane, index 0 is the newest
    typedef code_t [`FFE_TAPS-1:0] code_window_t;

    typedef struct packed {
        ffe_coef_t [`FFE_TAPS-1:0] weights;
        logic [`FFE_SHIFT_W-1:0] shift;
        est_t thresh;
    } ffe_cfg_t;

    typedef struct packed {
        chan_coef_t [`CHAN_TAPS-1:0] taps;
        logic [`CHAN_SHIFT_W-1:0] shift;
    } chan_cfg_t;

    // Registered output of one lane
    typedef struct packed {
        logic slice_bit;
        est_t est;
    } lane_result_t;

    typedef logic [`LANES-1:0] bit_vec_t;

    typedef err_t [`LANES-1:0] err_vec_t;

endpackage

`default_nettype wire

/* logic/code_window_builder.sv */
`include "dsp_settings.svh"
`default_nettype none

module code_window_builder
    import dsp_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire code_vec_t  codes_i,
    output code_window_t    windows_o [`LANES],
    output code_vec_t       code_dly_o
);

    localparam int HIST = `FFE_TAPS - 1;

    code_vec_t cur_q;
    code_vec_t prev_q;

    // Current vector with the tail of the previous one below it
    code_t [`LANES+HIST-1:0] code_hist;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cur_q  <= '0;
            prev_q <= '0;
        end else begin
            cur_q  <= codes_i;
            prev_q <= cur_q;
        end
    end

    assign code_hist = {cur_q, prev_q[`LANES-1 -: HIST]};

    // Previous vector doubles as the delayed copy for the error path
    assign code_dly_o = prev_q;

    genvar lane;
    genvar tap;
    generate
        for (lane = 0; lane < `LANES; lane++) begin : g_lane
            for (tap = 0; tap < `FFE_TAPS; tap++) begin : g_tap
                // Tap j looks j serial positions back
                assign windows_o[lane][tap] = code_hist[lane + HIST - tap];
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* logic/lane_equalizer.sv */
`include "dsp_settings.svh"
`default_nettype none

module lane_equalizer
    import dsp_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire code_window_t window_i,
    input  wire ffe_cfg_t     ffe_cfg_i,
    output lane_result_t      result_o
);

    localparam int ACC_W = `CODE_W + `FFE_COEF_W + $clog2(`FFE_TAPS);

    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] shifted;
    est_t est_sat;
    logic slice_bit;

    // Clamp to the estimate range when the upper bits disagree with the sign
    function automatic est_t sat_est(input logic signed [ACC_W-1:0] value);
        logic [ACC_W-`EST_W:0] top;
        top = value[ACC_W-1:`EST_W-1];
        if ((&top) || !(|top)) begin
            return value[`EST_W-1:0];
        end
        return {value[ACC_W-1], {(`EST_W-1){~value[ACC_W-1]}}};
    endfunction

    always_comb begin
        acc = '0;
        for (int tap = 0; tap < `FFE_TAPS; tap++) begin
            acc = acc + window_i[tap] * ffe_cfg_i.weights[tap];
        end
    end

    // Arithmetic shift keeps the sign
    assign shifted = acc >>> ffe_cfg_i.shift;

    assign est_sat = sat_est(shifted);

    assign slice_bit = (est_sat >= ffe_cfg_i.thresh);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o <= '0;
        end else begin
            result_o.slice_bit <= slice_bit;
            result_o.est       <= est_sat;
        end
    end

endmodule

`default_nettype wire

/* logic/residual_detector.sv */
`include "dsp_settings.svh"
`default_nettype none

module residual_detector
    import dsp_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         reset_i,
    input  wire lane_result_t results_i [`LANES],
    input  wire code_vec_t    code_dly_i,
    input  wire chan_cfg_t    chan_cfg_i,
    output bit_vec_t          bits_o,
    output err_vec_t          errors_o,
    output bit_vec_t          flips_o
);

    localparam int HIST  = `CHAN_TAPS - 1;
    localparam int ACC_W = `CHAN_COEF_W + 4;
    localparam int SQ_W  = 2 * ACC_W;

    bit_vec_t cur_bits;
    bit_vec_t prev_bits_q;
    logic [`LANES+HIST-1:0] bit_hist;

    logic signed [ACC_W-1:0] expected [`LANES];
    err_vec_t err_next;

    bit_vec_t bits_q;
    err_vec_t err_q;

    bit_vec_t flip_next;

    function automatic err_t sat_err(input logic signed [ACC_W-1:0] value);
        logic [ACC_W-`ERR_W:0] top;
        top = value[ACC_W-1:`ERR_W-1];
        if ((&top) || !(|top)) begin
            return value[`ERR_W-1:0];
        end
        return {value[ACC_W-1], {(`ERR_W-1){~value[ACC_W-1]}}};
    endfunction

    always_comb begin
        for (int lane = 0; lane < `LANES; lane++) begin
            cur_bits[lane] = results_i[lane].slice_bit;
        end
    end

    // Lane 0 reaches back into the last bits of the previous vector
    assign bit_hist = {cur_bits, prev_bits_q[`LANES-1 -: HIST]};

    // Stage one: channel filter and residual
    always_comb begin
        logic signed [ACC_W-1:0] acc;
        logic signed [ACC_W-1:0] tap_ext;
        logic signed [ACC_W-1:0] diff;
        for (int lane = 0; lane < `LANES; lane++) begin
            acc = '0;
            for (int tap = 0; tap < `CHAN_TAPS; tap++) begin
                tap_ext = chan_cfg_i.taps[tap];
                // Symbol +1 for bit 1, -1 for bit 0
                if (bit_hist[lane + HIST - tap]) begin
                    acc = acc + tap_ext;
                end else begin
                    acc = acc - tap_ext;
                end
            end
            expected[lane] = acc >>> chan_cfg_i.shift;
            diff = expected[lane] - code_dly_i[lane];
            err_next[lane] = sat_err(diff);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_bits_q <= '0;
            bits_q      <= '0;
            err_q       <= '0;
        end else begin
            prev_bits_q <= cur_bits;
            bits_q      <= cur_bits;
            err_q       <= err_next;
        end
    end

    // Stage two: would flipping this decision shrink the squared error
    always_comb begin
        logic signed [ACC_W-1:0] delta;
        logic signed [ACC_W-1:0] err_ext;
        logic signed [ACC_W-1:0] err_alt;
        logic signed [ACC_W-1:0] tap0_x2;
        logic signed [SQ_W-1:0] sq_err;
        logic signed [SQ_W-1:0] sq_alt;
        tap0_x2 = chan_cfg_i.taps[0];
        tap0_x2 = tap0_x2 <<< 1;
        for (int lane = 0; lane < `LANES; lane++) begin
            if (bits_q[lane]) begin
                delta = tap0_x2 >>> chan_cfg_i.shift;
            end else begin
                delta = (-tap0_x2) >>> chan_cfg_i.shift;
            end
            err_ext = err_q[lane];
            err_alt = err_ext - delta;
            sq_err = err_ext * err_ext;
            sq_alt = err_alt * err_alt;
            flip_next[lane] = (sq_alt < sq_err);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bits_o   <= '0;
            errors_o <= '0;
            flips_o  <= '0;
        end else begin
            bits_o   <= bits_q;
            errors_o <= err_q;
            flips_o  <= flip_next;
        end
    end

endmodule

`default_nettype wire

/* logic/rx_datapath.sv */
`include "dsp_settings.svh"
`default_nettype none

module rx_datapath
    import dsp_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire code_vec_t codes_i,
    input  wire ffe_cfg_t  ffe_cfg_i,
    input  wire chan_cfg_t chan_cfg_i,
    output bit_vec_t       bits_o,
    output err_vec_t       errors_o,
    output bit_vec_t       flips_o
);

    code_window_t windows [`LANES];
    code_vec_t    code_dly;
    lane_result_t results [`LANES];

    code_window_builder u_builder (
        .clk        (clk),
        .reset_i    (reset_i),
        .codes_i    (codes_i),
        .windows_o  (windows),
        .code_dly_o (code_dly)
    );

    // One equalizer and slicer per lane
    genvar lane;
    generate
        for (lane = 0; lane < `LANES; lane++) begin : g_lane
            lane_equalizer u_lane (
                .clk       (clk),
                .reset_i   (reset_i),
                .window_i  (windows[lane]),
                .ffe_cfg_i (ffe_cfg_i),
                .result_o  (results[lane])
            );
        end
    endgenerate

    residual_detector u_detector (
        .clk        (clk),
        .reset_i    (reset_i),
        .results_i  (results),
        .code_dly_i (code_dly),
        .chan_cfg_i (chan_cfg_i),
        .bits_o     (bits_o),
        .errors_o   (errors_o),
        .flips_o    (flips_o)
    );

endmodule

`default_nettype wire

/* sim/tb_rx_datapath.sv */
`include "dsp_settings.svh"
`default_nettype none

module tb_rx_datapath
    import dsp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY      = 4;
    localparam int RESET_CYCLES = 16;
    localparam int GAP_CYCLES   = 2;
    localparam int STREAM_TESTS = 4;
    localparam int VECTORS      = 100;
    localparam int MARGIN       = 50;
    // Each stream adds its vectors, the drain, the reset gap and one spare cycle
    localparam int MAX_CYCLES   = RESET_CYCLES
                                  + STREAM_TESTS * (VECTORS + LATENCY + GAP_CYCLES + 1)
                                  + MARGIN;

    localparam int FFE_HIST  = `FFE_TAPS - 1;
    localparam int CHAN_HIST = `CHAN_TAPS - 1;

    localparam int KIND_PASS    = 0;
    localparam int KIND_FULL    = 1;
    localparam int KIND_CHANNEL = 2;
    localparam int KIND_NOISY   = 3;

    typedef struct packed {
        bit_vec_t bits;
        err_vec_t errors;
        bit_vec_t flips;
    } expect_t;

    typedef struct {
        code_vec_t codes;
        int due;
    } sent_t;

    logic      clk;
    logic      reset_i;
    code_vec_t codes_i;
    ffe_cfg_t  ffe_cfg_i;
    chan_cfg_t chan_cfg_i;
    bit_vec_t  bits_o;
    err_vec_t  errors_o;
    bit_vec_t  flips_o;

    int        cycle_count;
    sent_t     sent_q[$];
    string     test_name;
    int        test_kind;
    code_vec_t model_prev_codes;
    bit_vec_t  model_prev_bits;
    bit_vec_t  pat_prev;

    rx_datapath rx_datapath_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .codes_i    (codes_i),
        .ffe_cfg_i  (ffe_cfg_i),
        .chan_cfg_i (chan_cfg_i),
        .bits_o     (bits_o),
        .errors_o   (errors_o),
        .flips_o    (flips_o)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic check_bits(input string what, input bit_vec_t expected,
                              input bit_vec_t actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %b actual %b", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_errors(input string what, input err_vec_t expected,
                                input err_vec_t actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flips(input string what, input bit_vec_t expected,
                               input bit_vec_t actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %b actual %b", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    function automatic int saturate(input int value, input int width);
        int hi;
        int lo;
        hi = (1 <<< (width - 1)) - 1;
        lo = -(1 <<< (width - 1));
        if (value > hi) begin
            return hi;
        end
        if (value < lo) begin
            return lo;
        end
        return value;
    endfunction

    // Expected outputs for one vector, carrying code and bit history along
    function automatic expect_t reference_step(input code_vec_t codes);
        expect_t result;
        int code_seq [`LANES + FFE_HIST];
        logic [`LANES+CHAN_HIST-1:0] bit_seq;
        int acc;
        int est;
        int err;
        int delta;
        int sym;
        result = '0;
        for (int i = 0; i < FFE_HIST; i++) begin
            code_seq[i] = $signed(model_prev_codes[`LANES - FFE_HIST + i]);
        end
        for (int lane = 0; lane < `LANES; lane++) begin
            code_seq[lane + FFE_HIST] = $signed(codes[lane]);
        end
        for (int lane = 0; lane < `LANES; lane++) begin
            acc = 0;
            for (int j = 0; j < `FFE_TAPS; j++) begin
                acc += int'($signed(ffe_cfg_i.weights[j])) * code_seq[lane + FFE_HIST - j];
            end
            est = saturate(acc >>> ffe_cfg_i.shift, `EST_W);
            result.bits[lane] = (est >= int'($signed(ffe_cfg_i.thresh)));
        end
        bit_seq = {result.bits, model_prev_bits[`LANES-1 -: CHAN_HIST]};
        for (int lane = 0; lane < `LANES; lane++) begin
            acc = 0;
            for (int j = 0; j < `CHAN_TAPS; j++) begin
                sym = bit_seq[lane + CHAN_HIST - j] ? 1 : -1;
                acc += int'($signed(chan_cfg_i.taps[j])) * sym;
            end
            err = saturate((acc >>> chan_cfg_i.shift) - int'($signed(codes[lane])), `ERR_W);
            result.errors[lane] = err_t'(err);
            sym = result.bits[lane] ? 1 : -1;
            delta = (2 * int'($signed(chan_cfg_i.taps[0])) * sym) >>> chan_cfg_i.shift;
            result.flips[lane] = ((err - delta) * (err - delta)) < (err * err);
        end
        model_prev_codes = codes;
        model_prev_bits  = result.bits;
        return result;
    endfunction

    task automatic model_reset();
        model_prev_codes = '0;
        // Zero codes give a zero estimate, sliced against the threshold
        model_prev_bits = (0 >= int'($signed(ffe_cfg_i.thresh))) ? '1 : '0;
    endtask

    function automatic ffe_cfg_t passthrough_ffe();
        ffe_cfg_t cfg;
        cfg = '0;
        cfg.weights[0] = 1;
        return cfg;
    endfunction

    function automatic ffe_cfg_t random_ffe();
        ffe_cfg_t cfg;
        for (int j = 0; j < `FFE_TAPS; j++) begin
            cfg.weights[j] = ffe_coef_t'($urandom());
        end
        cfg.shift  = $urandom_range(6, 0);
        cfg.thresh = est_t'(int'($urandom_range(255, 0)) - 128);
        return cfg;
    endfunction

    function automatic chan_cfg_t known_channel();
        chan_cfg_t cfg;
        cfg.taps[0] = 64;
        cfg.taps[1] = 32;
        cfg.taps[2] = -16;
        cfg.shift   = 1;
        return cfg;
    endfunction

    function automatic chan_cfg_t random_channel();
        chan_cfg_t cfg;
        for (int j = 0; j < `CHAN_TAPS; j++) begin
            cfg.taps[j] = chan_coef_t'($urandom());
        end
        cfg.shift = $urandom_range(7, 0);
        return cfg;
    endfunction

    function automatic code_vec_t random_codes();
        code_vec_t v;
        for (int lane = 0; lane < `LANES; lane++) begin
            v[lane] = code_t'($urandom());
        end
        return v;
    endfunction

    function automatic code_vec_t full_scale_codes();
        code_vec_t v;
        for (int lane = 0; lane < `LANES; lane++) begin
            case ($urandom_range(2, 0))
                0: v[lane] = code_t'(127);
                1: v[lane] = code_t'(-128);
                default: v[lane] = code_t'($urandom());
            endcase
        end
        return v;
    endfunction

    // Random bit pattern sent through the configured channel
    function automatic code_vec_t channel_codes(input logic noisy);
        code_vec_t v;
        bit_vec_t pattern;
        bit_vec_t noise_lanes;
        logic [`LANES+CHAN_HIST-1:0] seq;
        int acc;
        int sym;
        pattern = bit_vec_t'($urandom());
        noise_lanes = bit_vec_t'($urandom() & $urandom());
        noise_lanes[0] = 1'($urandom_range(1, 0));
        seq = {pattern, pat_prev[`LANES-1 -: CHAN_HIST]};
        for (int lane = 0; lane < `LANES; lane++) begin
            acc = 0;
            for (int j = 0; j < `CHAN_TAPS; j++) begin
                sym = seq[lane + CHAN_HIST - j] ? 1 : -1;
                acc += int'($signed(chan_cfg_i.taps[j])) * sym;
            end
            acc = acc >>> chan_cfg_i.shift;
            if (noisy && noise_lanes[lane]) begin
                acc += int'($urandom_range(120, 0)) - 60;
            end
            v[lane] = code_t'(saturate(acc, `CODE_W));
        end
        pat_prev = pattern;
        return v;
    endfunction

    task automatic send_vector(input code_vec_t v);
        sent_t entry;
        codes_i = v;
        entry.codes = v;
        entry.due = cycle_count + LATENCY;
        sent_q.push_back(entry);
    endtask

    task automatic check_idle();
        check_bits("bits idle", '0, bits_o);
        check_errors("errors idle", '0, errors_o);
        check_flips("flips idle", '0, flips_o);
    endtask

    // Called on a falling edge, returns on a falling edge with reset still high
    task automatic apply_reset(input string name, input int cycles);
        test_name = name;
        reset_i = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            codes_i = random_codes();
            @(negedge clk);
            check_idle();
        end
    endtask

    task automatic run_stream(input string name, input int kind);
        code_vec_t v;
        test_name = name;
        test_kind = kind;
        model_reset();
        // Slicer history after reset is a zero code, which slices to 1 here
        pat_prev = '1;
        reset_i = 1'b0;
        for (int i = 0; i < VECTORS; i++) begin
            case (kind)
                KIND_PASS: v = random_codes();
                KIND_FULL: v = full_scale_codes();
                KIND_CHANNEL: v = channel_codes(1'b0);
                default: v = channel_codes(1'b1);
            endcase
            send_vector(v);
            @(negedge clk);
            // Only reset values have reached the outputs so far
            if (i == 0) begin
                check_idle();
            end
        end
        codes_i = '0;
        while (sent_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        sent_t entry;
        expect_t expected;
        bit_vec_t sign_bits;
        if (sent_q.size() != 0 && sent_q[0].due == cycle_count) begin
            entry = sent_q.pop_front();
            expected = reference_step(entry.codes);
            check_bits("bits", expected.bits, bits_o);
            check_errors("errors", expected.errors, errors_o);
            check_flips("flips", expected.flips, flips_o);
            if (test_kind == KIND_PASS) begin
                for (int lane = 0; lane < `LANES; lane++) begin
                    sign_bits[lane] = ($signed(entry.codes[lane]) >= 0);
                end
                check_bits("sign", sign_bits, bits_o);
            end
            if (test_kind == KIND_CHANNEL) begin
                check_errors("errors zero", '0, errors_o);
            end
        end
    end

    initial begin : main_sequence
        void'($urandom(94131));
        clk = 1'b0;
        reset_i = 1'b1;
        codes_i = '0;
        ffe_cfg_i = passthrough_ffe();
        chan_cfg_i = known_channel();
        @(negedge clk);
        apply_reset("reset", RESET_CYCLES);
        run_stream("passthrough", KIND_PASS);

        ffe_cfg_i = random_ffe();
        chan_cfg_i = random_channel();
        apply_reset("random_ffe", GAP_CYCLES);
        run_stream("random_ffe", KIND_FULL);

        ffe_cfg_i = passthrough_ffe();
        chan_cfg_i = known_channel();
        apply_reset("channel_match", GAP_CYCLES);
        run_stream("channel_match", KIND_CHANNEL);

        apply_reset("channel_noise", GAP_CYCLES);
        run_stream("channel_noise", KIND_NOISY);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
logic/dsp_pkg.sv
logic/code_window_builder.sv
logic/lane_equalizer.sv
logic/residual_detector.sv
logic/rx_datapath.sv
sim/tb_rx_datapath.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP       := tb_rx_datapath
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES   := $(wildcard include/*.svh logic/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
